//--- Makefile
# Verilator simulation of the CP0 core

VERILATOR ?= verilator
TOP       ?= cp0Tb
BUILD_DIR ?= build
FILELIST  ?= files.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "test passed"

clean:
	rm -rf $(BUILD_DIR)

//--- files.f
+incdir+tests
hdl/cp0Pkg.sv
hdl/cp0WriteIf.sv
hdl/cp0Timer.sv
hdl/cp0ExceptionCtrl.sv
hdl/cp0RegFile.sv
hdl/cp0Top.sv
tests/cp0Tb.sv

//--- hdl/cp0ExceptionCtrl.sv
//////////////////////////////////////////////////
// CP0 exception-level controller
// Tracks EXL as a two-state machine and records
// EPC, Cause.BD, Cause.ExcCode and BadVAddr
//////////////////////////////////////////////////
`timescale 1ns/1ns

module cp0ExceptionCtrl (
    input  logic                         clk,
    input  logic                         reset,
    cp0WriteIf.sink                      wr,
    input  cp0Pkg::excType_e             excType,
    input  logic [cp0Pkg::dataWidth-1:0] excPc,
    input  logic                         inDelaySlot,
    input  logic [cp0Pkg::dataWidth-1:0] excAddr,
    output logic                         exl,
    output logic [cp0Pkg::dataWidth-1:0] epc,
    output logic [cp0Pkg::dataWidth-1:0] badVAddr,
    output logic                         causeBd,
    output logic [4:0]                   excCode
);
    import cp0Pkg::*;

    regWord_u   wrWord;
    logic       statusWr;
    logic       epcWr;
    logic       takeExc;
    logic       isEret;
    logic       recordEpc;
    logic       nextExl;
    logic       codeValid;
    logic [4:0] newCode;

    assign wrWord.raw = wr.wrData;
    assign statusWr   = wr.wrEn && (wr.wrAddr == addrStatus);
    assign epcWr      = wr.wrEn && (wr.wrAddr == addrEpc);

    // Refetch is a pipeline replay, not a real exception
    assign takeExc   = (excType != excNone) && (excType != excRefetch);
    assign isEret    = (excType == excEret);
    assign recordEpc = takeExc && !isEret && !exl;

    always_comb begin
        codeValid = excCodeOf(excType, newCode);
    end

    // Exceptions take priority over a Status write
    always_comb begin
        nextExl = exl;
        if (takeExc) begin
            nextExl = !isEret;  // Eret returns to normal level
        end else if (statusWr) begin
            nextExl = wrWord.status.exl;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            exl <= 1'b0;
        end else begin
            exl <= nextExl;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            epc     <= '0;
            causeBd <= 1'b0;
        end else if (recordEpc) begin
            epc     <= inDelaySlot ? excPc - dataWidth'(4) : excPc;  // Point at the branch
            causeBd <= inDelaySlot;
        end else if (epcWr) begin
            epc <= wr.wrData;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            excCode <= codeInt;
        end else if (codeValid) begin
            excCode <= newCode;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            badVAddr <= '0;
        end else if (excType == excAddrErrFetch) begin
            badVAddr <= excPc;
        end else if (excType == excAddrErrLoad || excType == excAddrErrStore) begin
            badVAddr <= excAddr;
        end
    end

    excTypeKnown: assert property (
        @(posedge clk) disable iff (reset)
        !$isunknown(excType)
    );

endmodule

//--- hdl/cp0Pkg.sv
//////////////////////////////////////////////////
// CP0 shared definitions
// Register addresses, exception types, ExcCode
// values and the Status/Cause word layouts
//////////////////////////////////////////////////
package cp0Pkg;

    localparam int dataWidth = 32;

    typedef logic [4:0] regAddr_t;
    typedef logic [2:0] regSel_t;

    localparam regAddr_t addrBadVAddr = 5'd8;
    localparam regAddr_t addrCount    = 5'd9;
    localparam regAddr_t addrCompare  = 5'd11;
    localparam regAddr_t addrStatus   = 5'd12;
    localparam regAddr_t addrCause    = 5'd13;
    localparam regAddr_t addrEpc      = 5'd14;
    localparam regAddr_t addrPrid     = 5'd15;  // Sel 0 PRId, sel 1 EBase

    typedef enum logic [4:0] {
        excNone,
        excInterrupt,
        excAddrErrFetch,
        excAddrErrLoad,
        excAddrErrStore,
        excSyscall,
        excBreak,
        excReservedInstr,
        excOverflow,
        excTrap,
        excEret,
        excRefetch
    } excType_e;

    localparam logic [4:0] codeInt  = 5'h00;
    localparam logic [4:0] codeAdEL = 5'h04;
    localparam logic [4:0] codeAdES = 5'h05;
    localparam logic [4:0] codeSys  = 5'h08;
    localparam logic [4:0] codeBp   = 5'h09;
    localparam logic [4:0] codeRI   = 5'h0a;
    localparam logic [4:0] codeOv   = 5'h0c;
    localparam logic [4:0] codeTr   = 5'h0d;

    localparam logic [dataWidth-1:0] pridValue  = 32'h0000_4220;
    localparam logic [dataWidth-1:0] ebaseReset = 32'h8000_0000;

    typedef struct packed {
        logic [8:0] rsvdHi;
        logic       bev;
        logic [5:0] rsvdMid;
        logic [7:0] im;
        logic [5:0] rsvdLo;
        logic       exl;
        logic       ie;
    } statusBits_s;

    typedef struct packed {
        logic        bd;
        logic        ti;
        logic [13:0] rsvdHi;
        logic [7:0]  ip;
        logic        rsvdMid;
        logic [4:0]  excCode;
        logic [1:0]  rsvdLo;
    } causeBits_s;

    // Same word seen as Status or Cause depending on the address
    typedef union packed {
        logic [dataWidth-1:0] raw;
        statusBits_s          status;
        causeBits_s           cause;
    } regWord_u;

    // Returns 0 for types that carry no ExcCode
    function automatic logic excCodeOf(input excType_e excType, output logic [4:0] code);
        logic valid;
        valid = 1'b1;
        code  = codeInt;
        case (excType)
            excInterrupt:     code = codeInt;
            excAddrErrFetch:  code = codeAdEL;
            excAddrErrLoad:   code = codeAdEL;
            excAddrErrStore:  code = codeAdES;
            excSyscall:       code = codeSys;
            excBreak:         code = codeBp;
            excReservedInstr: code = codeRI;
            excOverflow:      code = codeOv;
            excTrap:          code = codeTr;
            default:          valid = 1'b0;
        endcase
        return valid;
    endfunction

endpackage

//--- hdl/cp0RegFile.sv
//////////////////////////////////////////////////
// CP0 register file
// Status, Cause IP bits, PRId and EBase storage
// plus the combinational read multiplexer
//////////////////////////////////////////////////
`timescale 1ns/1ns

module cp0RegFile (
    input  logic                         clk,
    input  logic                         reset,
    cp0WriteIf.sink                      wr,
    input  logic [5:0]                   interrupt,
    input  logic                         timerIrq,
    input  logic [cp0Pkg::dataWidth-1:0] count,
    input  logic [cp0Pkg::dataWidth-1:0] compare,
    input  logic                         causeTi,
    input  logic                         exl,
    input  logic [cp0Pkg::dataWidth-1:0] epc,
    input  logic [cp0Pkg::dataWidth-1:0] badVAddr,
    input  logic                         causeBd,
    input  logic [4:0]                   excCode,
    input  cp0Pkg::regAddr_t             rdAddr,
    input  cp0Pkg::regSel_t              rdSel,
    output logic [cp0Pkg::dataWidth-1:0] rdData,
    output logic                         statusBev,
    output logic [7:0]                   statusIm,
    output logic                         statusIe,
    output logic [7:0]                   causeIp,
    output logic [cp0Pkg::dataWidth-1:0] ebase
);
    import cp0Pkg::*;

    regWord_u wrWord;
    regWord_u statusWord;
    regWord_u causeWord;
    logic     statusWr;
    logic     causeWr;
    logic     ebaseWr;

    assign wrWord.raw = wr.wrData;
    assign statusWr   = wr.wrEn && (wr.wrAddr == addrStatus);
    assign causeWr    = wr.wrEn && (wr.wrAddr == addrCause);
    assign ebaseWr    = wr.wrEn && (wr.wrAddr == addrPrid) && (wr.wrSel == 3'd1);

    always_ff @(posedge clk) begin
        if (reset) begin
            statusBev <= 1'b1;
            statusIm  <= '0;
            statusIe  <= 1'b0;
        end else if (statusWr) begin
            statusBev <= wrWord.status.bev;
            statusIm  <= wrWord.status.im;
            statusIe  <= wrWord.status.ie;
        end
    end

    // Timer shares IP7 with the top hardware line
    always_ff @(posedge clk) begin
        if (reset) begin
            causeIp <= '0;
        end else begin
            causeIp[7:2] <= interrupt | {timerIrq, 5'b0};
            if (causeWr) begin
                causeIp[1:0] <= wrWord.cause.ip[1:0];  // Software interrupts
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ebase <= ebaseReset;
        end else if (ebaseWr) begin
            ebase[29:12] <= wr.wrData[29:12];  // Exception base only
        end
    end

    always_comb begin
        statusWord.raw        = '0;
        statusWord.status.bev = statusBev;
        statusWord.status.im  = statusIm;
        statusWord.status.exl = exl;
        statusWord.status.ie  = statusIe;
    end

    always_comb begin
        causeWord.raw           = '0;
        causeWord.cause.bd      = causeBd;
        causeWord.cause.ti      = causeTi;
        causeWord.cause.ip      = causeIp;
        causeWord.cause.excCode = excCode;
    end

    always_comb begin
        case (rdAddr)
            addrBadVAddr: rdData = badVAddr;
            addrCount:    rdData = count;
            addrCompare:  rdData = compare;
            addrStatus:   rdData = statusWord.raw;
            addrCause:    rdData = causeWord.raw;
            addrEpc:      rdData = epc;
            addrPrid: begin
                if (rdSel == 3'd0) begin
                    rdData = pridValue;
                end else if (rdSel == 3'd1) begin
                    rdData = ebase;
                end else begin
                    rdData = '0;
                end
            end
            default:      rdData = '0;   // Unimplemented
        endcase
    end

    // Vector base must stay in kseg0/kseg1
    ebaseTopBits: assert property (
        @(posedge clk) disable iff (reset)
        ebase[31:30] == 2'b10
    );

endmodule

//--- hdl/cp0Timer.sv
//////////////////////////////////////////////////
// CP0 Count/Compare timer
// Count advances every second cycle, the timer
// interrupt fires while Count equals Compare and
// Cause.TI stays set until Compare is written
//////////////////////////////////////////////////
`timescale 1ns/1ns

module cp0Timer (
    input  logic                         clk,
    input  logic                         reset,
    cp0WriteIf.sink                      wr,
    output logic [cp0Pkg::dataWidth-1:0] count,
    output logic [cp0Pkg::dataWidth-1:0] compare,
    output logic                         timerIrq,
    output logic                         causeTi
);
    import cp0Pkg::*;

    logic half;   // Divider bit
    logic countWr;
    logic compareWr;

    assign countWr   = wr.wrEn && (wr.wrAddr == addrCount);
    assign compareWr = wr.wrEn && (wr.wrAddr == addrCompare);

    always_ff @(posedge clk) begin
        if (reset) begin
            half  <= 1'b0;
            count <= '0;
        end else if (countWr) begin
            half  <= 1'b0;   // Restart the half-rate phase
            count <= wr.wrData;
        end else begin
            half <= ~half;
            if (half) begin
                count <= count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            compare <= '1;
        end else if (compareWr) begin
            compare <= wr.wrData;
        end
    end

    assign timerIrq = (count == compare);

    always_ff @(posedge clk) begin
        if (reset) begin
            causeTi <= 1'b0;
        end else if (compareWr) begin
            causeTi <= 1'b0;  // Compare write acknowledges the timer
        end else if (timerIrq) begin
            causeTi <= 1'b1;
        end
    end

    // Count only ever steps by one unless software loads it
    countStepCheck: assert property (
        @(posedge clk) disable iff (reset)
        (!$past(reset) && !$past(countWr)) |->
            (count == $past(count) || count == $past(count) + 1'b1)
    );

endmodule

//--- hdl/cp0Top.sv
//////////////////////////////////////////////////
// CP0 exception and timer core, top level
// Joins the pipeline ports to the timer, the
// exception controller and the register file
//////////////////////////////////////////////////
`timescale 1ns/1ns

module cp0Top (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         wrEn,
    input  cp0Pkg::regAddr_t             wrAddr,
    input  cp0Pkg::regSel_t              wrSel,
    input  logic [cp0Pkg::dataWidth-1:0] wrData,
    input  cp0Pkg::regAddr_t             rdAddr,
    input  cp0Pkg::regSel_t              rdSel,
    output logic [cp0Pkg::dataWidth-1:0] rdData,
    input  logic [5:0]                   interrupt,
    input  cp0Pkg::excType_e             excType,
    input  logic [cp0Pkg::dataWidth-1:0] excPc,
    input  logic                         inDelaySlot,
    input  logic [cp0Pkg::dataWidth-1:0] excAddr,
    output logic                         statusBev,
    output logic [7:0]                   statusIm,
    output logic                         statusExl,
    output logic                         statusIe,
    output logic [7:0]                   causeIp,
    output logic [cp0Pkg::dataWidth-1:0] epc,
    output logic [cp0Pkg::dataWidth-1:0] ebase
);
    import cp0Pkg::*;

    logic [dataWidth-1:0] count;
    logic [dataWidth-1:0] compare;
    logic [dataWidth-1:0] badVAddr;
    logic                 timerIrq;
    logic                 causeTi;
    logic                 causeBd;
    logic [4:0]           excCode;

    cp0WriteIf wrBus ();

    assign wrBus.wrEn   = wrEn;
    assign wrBus.wrAddr = wrAddr;
    assign wrBus.wrSel  = wrSel;
    assign wrBus.wrData = wrData;

    cp0Timer timer (
        .clk, .reset, .wr(wrBus.sink),
        .count, .compare, .timerIrq, .causeTi
    );

    cp0ExceptionCtrl excCtrl (
        .clk, .reset, .wr(wrBus.sink),
        .excType, .excPc, .inDelaySlot, .excAddr,
        .exl(statusExl), .epc, .badVAddr, .causeBd, .excCode
    );

    cp0RegFile regFile (
        .clk, .reset, .wr(wrBus.sink),
        .interrupt, .timerIrq, .count, .compare, .causeTi,
        .exl(statusExl), .epc, .badVAddr, .causeBd, .excCode,
        .rdAddr, .rdSel, .rdData,
        .statusBev, .statusIm, .statusIe, .causeIp, .ebase
    );

endmodule

//--- hdl/cp0WriteIf.sv
//////////////////////////////////////////////////
// CP0 register write bus
// Single-cycle strobe with address, select, data
//////////////////////////////////////////////////
`timescale 1ns/1ns

interface cp0WriteIf;
    import cp0Pkg::*;

    logic                 wrEn;
    regAddr_t             wrAddr;
    regSel_t              wrSel;
    logic [dataWidth-1:0] wrData;

    modport source (output wrEn, output wrAddr, output wrSel, output wrData);
    modport sink (input wrEn, input wrAddr, input wrSel, input wrData);

endinterface

//--- tests/cp0TbModel.svh
//////////////////////////////////////////////////
// CP0 testbench model
// Shadow registers stepped once per clock edge,
// reference read words and the LFSR source
//////////////////////////////////////////////////

logic [15:0] lfsrState = 16'd75;

logic [dataWidth-1:0] shCount;
logic [dataWidth-1:0] shCompare;
logic [dataWidth-1:0] shEpc;
logic [dataWidth-1:0] shBadVAddr;
logic [dataWidth-1:0] shEbase;
logic                 shHalf;
logic                 shTi;
logic                 shBev;
logic                 shIe;
logic                 shExl;
logic                 shBd;
logic [7:0]           shIm;
logic [7:0]           shIp;
logic [4:0]           shCode;

// x^16 + x^15 + x^13 + x^4 + 1
function automatic logic lfsrBit();
    logic fb;
    fb = lfsrState[15] ^ lfsrState[14] ^ lfsrState[12] ^ lfsrState[3];
    lfsrState = {lfsrState[14:0], fb};
    return fb;
endfunction

function automatic logic [31:0] randomBits(input int width);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < width; i++) begin
        value = {value[30:0], lfsrBit()};
    end
    return value;
endfunction

function automatic logic excCodeFor(input excType_e t, output logic [4:0] code);
    code = 5'h00;
    case (t)
        excInterrupt:     code = codeInt;
        excAddrErrFetch:  code = codeAdEL;
        excAddrErrLoad:   code = codeAdEL;
        excAddrErrStore:  code = codeAdES;
        excSyscall:       code = codeSys;
        excBreak:         code = codeBp;
        excReservedInstr: code = codeRI;
        excOverflow:      code = codeOv;
        excTrap:          code = codeTr;
        default:          return 1'b0;  // None, Eret, Refetch
    endcase
    return 1'b1;
endfunction

task automatic resetShadow();
    shCount    = '0;
    shHalf     = 1'b0;
    shCompare  = '1;
    shEpc      = '0;
    shBadVAddr = '0;
    shEbase    = ebaseReset;
    shTi       = 1'b0;
    shBev      = 1'b1;
    shIe       = 1'b0;
    shExl      = 1'b0;
    shBd       = 1'b0;
    shIm       = '0;
    shIp       = '0;
    shCode     = '0;
endtask

// Next state from the inputs held across the edge
task automatic advanceShadow();
    regWord_u   w;
    logic       countHit;
    logic       take;
    logic       eret;
    logic       valid;
    logic [4:0] code;
    w.raw    = wrData;
    countHit = (shCount == shCompare);
    take     = (excType != excNone) && (excType != excRefetch);
    eret     = (excType == excEret);
    valid    = excCodeFor(excType, code);
    shIp[7:2] = interrupt | {countHit, 5'b0};
    if (wrEn && wrAddr == addrCause) begin
        shIp[1:0] = w.cause.ip[1:0];
    end
    if (wrEn && wrAddr == addrCompare) begin
        shTi      = 1'b0;
        shCompare = wrData;
    end else if (countHit) begin
        shTi = 1'b1;
    end
    if (wrEn && wrAddr == addrCount) begin
        shCount = wrData;
        shHalf  = 1'b0;
    end else begin
        if (shHalf) begin
            shCount = shCount + 32'd1;
        end
        shHalf = !shHalf;
    end
    if (take && !eret && !shExl) begin
        shEpc = inDelaySlot ? excPc - 32'd4 : excPc;
        shBd  = inDelaySlot;
    end else if (wrEn && wrAddr == addrEpc) begin
        shEpc = wrData;
    end
    if (valid) begin
        shCode = code;
    end
    if (excType == excAddrErrFetch) begin
        shBadVAddr = excPc;
    end else if (excType == excAddrErrLoad || excType == excAddrErrStore) begin
        shBadVAddr = excAddr;
    end
    if (wrEn && wrAddr == addrStatus) begin
        shBev = w.status.bev;
        shIm  = w.status.im;
        shIe  = w.status.ie;
    end
    if (take) begin
        shExl = !eret;
    end else if (wrEn && wrAddr == addrStatus) begin
        shExl = w.status.exl;
    end
    if (wrEn && wrAddr == addrPrid && wrSel == 3'd1) begin
        shEbase[29:12] = wrData[29:12];
    end
endtask

function automatic logic [31:0] expectedRead(input regAddr_t addr, input regSel_t sel);
    regWord_u w;
    w.raw = '0;
    case (addr)
        addrBadVAddr: return shBadVAddr;
        addrCount:    return shCount;
        addrCompare:  return shCompare;
        addrStatus: begin
            w.status.bev = shBev;
            w.status.im  = shIm;
            w.status.exl = shExl;
            w.status.ie  = shIe;
            return w.raw;
        end
        addrCause: begin
            w.cause.bd      = shBd;
            w.cause.ti      = shTi;
            w.cause.ip      = shIp;
            w.cause.excCode = shCode;
            return w.raw;
        end
        addrEpc:      return shEpc;
        addrPrid:     return (sel == 3'd0) ? pridValue : (sel == 3'd1) ? shEbase : 32'd0;
        default:      return '0;
    endcase
endfunction

//--- tests/cp0Tb.sv
//////////////////////////////////////////////////
// CP0 core testbench
// Drives writes, exceptions and interrupt levels
// and checks every cycle against a shadow model
//////////////////////////////////////////////////
`timescale 1ns/1ns

module cp0Tb;
    import cp0Pkg::*;

    localparam int clkPeriod    = 8;
    localparam int testCycles   = 16 + 100 + 72 + 24 + 40 + 12;
    localparam int marginCycles = 100;

    logic                 clk;
    logic                 reset;
    logic                 wrEn;
    regAddr_t             wrAddr;
    regSel_t              wrSel;
    logic [dataWidth-1:0] wrData;
    regAddr_t             rdAddr;
    regSel_t              rdSel;
    logic [dataWidth-1:0] rdData;
    logic [5:0]           interrupt;
    excType_e             excType;
    logic [dataWidth-1:0] excPc;
    logic                 inDelaySlot;
    logic [dataWidth-1:0] excAddr;
    logic                 statusBev;
    logic [7:0]           statusIm;
    logic                 statusExl;
    logic                 statusIe;
    logic [7:0]           causeIp;
    logic [dataWidth-1:0] epc;
    logic [dataWidth-1:0] ebase;

    int    errorCount = 0;
    int    checkCount = 0;
    string testName;

    `include "cp0TbModel.svh"

    cp0Top UUT (
        .clk, .reset, .wrEn, .wrAddr, .wrSel, .wrData, .rdAddr, .rdSel, .rdData,
        .interrupt, .excType, .excPc, .inDelaySlot, .excAddr,
        .statusBev, .statusIm, .statusExl, .statusIe, .causeIp, .epc, .ebase
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    task automatic compareWord(input string what, input logic [31:0] exp, input logic [31:0] act);
        checkCount++;
        assert (act === exp) else begin
            errorCount++;
            $display("Fail %s %s: expected %h, actual %h", testName, what, exp, act);
        end
    endtask

    // Shadow steps at the edge, inputs change 1 ns later
    task automatic step(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            advanceShadow();
            #1;
        end
    endtask

    task automatic writeReg(input regAddr_t addr, input regSel_t sel, input logic [31:0] data);
        wrEn   = 1'b1;
        wrAddr = addr;
        wrSel  = sel;
        wrData = data;
        step(1);
        wrEn = 1'b0;
    endtask

    task automatic readReg(input regAddr_t addr, input regSel_t sel);
        rdAddr = addr;
        rdSel  = sel;
        step(1);
    endtask

    task automatic raiseException(input excType_e t, input logic [31:0] pc, input logic ds,
            input logic [31:0] addr);
        excType     = t;
        excPc       = pc;
        inDelaySlot = ds;
        excAddr     = addr;
        step(1);
        excType = excNone;
    endtask

    // Mid-cycle comparison of all outputs
    initial begin
        forever begin
            @(posedge clk);
            #6;
            if (!reset) begin
                compareWord("rdData", expectedRead(rdAddr, rdSel), rdData);
                compareWord("statusBev", 32'(shBev), 32'(statusBev));
                compareWord("statusIm", 32'(shIm), 32'(statusIm));
                compareWord("statusIe", 32'(shIe), 32'(statusIe));
                compareWord("statusExl", 32'(shExl), 32'(statusExl));
                compareWord("causeIp", 32'(shIp), 32'(causeIp));
                compareWord("epc", shEpc, epc);
                compareWord("ebase", shEbase, ebase);
            end
        end
    end

    initial begin
        #(clkPeriod * (testCycles + marginCycles));
        $display("Watchdog timeout after %0d cycles, run did not complete",
            testCycles + marginCycles);
        $display("test failed");
        $finish;
    end

    initial begin
        logic [31:0] value;
        logic [31:0] pc;
        logic [4:0]  pick;
        logic [5:0]  irq;
        logic        ds;
        int          n;
        int          k;
        reset       = 1'b1;
        wrEn        = 1'b0;
        wrAddr      = '0;
        wrSel       = '0;
        wrData      = '0;
        rdAddr      = '0;
        rdSel       = '0;
        interrupt   = '0;
        excType     = excNone;
        excPc       = '0;
        inDelaySlot = 1'b0;
        excAddr     = '0;
        testName    = "reset values";
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        resetShadow();
        rdAddr = addrCount;
        step(6);
        compareWord("count", 32'd3, rdData);
        readReg(addrStatus, 3'd0);
        readReg(addrCause, 3'd0);
        readReg(addrPrid, 3'd0);
        readReg(addrPrid, 3'd1);
        readReg(addrPrid, 3'd2);
        readReg(addrCompare, 3'd0);
        readReg(addrEpc, 3'd0);
        readReg(5'd3, 3'd0);        // Unimplemented

        testName = "register writes";
        repeat (8) begin
            writeReg(addrStatus, 3'd0, randomBits(32));
            readReg(addrStatus, 3'd0);
            writeReg(addrEpc, 3'd0, randomBits(32));
            readReg(addrEpc, 3'd0);
            writeReg(addrCompare, 3'd0, randomBits(32));
            readReg(addrCompare, 3'd0);
            writeReg(addrCause, 3'd0, randomBits(32));
            readReg(addrCause, 3'd0);
            writeReg(addrPrid, 3'd1, randomBits(32));
            readReg(addrPrid, 3'd1);
            writeReg(addrPrid, 3'd0, randomBits(32));
            readReg(addrPrid, 3'd0);
        end
        writeReg(addrCompare, 3'd0, '1);

        testName = "count timing";
        repeat (4) begin
            value  = randomBits(32);
            n      = int'(randomBits(3)) + 1;
            rdAddr = addrCount;
            rdSel  = 3'd0;
            writeReg(addrCount, 3'd0, value);
            step(2 * n);
            compareWord("count", value + 32'(n), rdData);
        end

        testName = "timer interrupt";
        value  = randomBits(16);
        k      = int'(randomBits(2)) + 2;
        rdAddr = addrCause;
        writeReg(addrCount, 3'd0, value);
        writeReg(addrCompare, 3'd0, value + 32'(k));
        step(2 * k - 1);
        compareWord("causeIp7 early", 32'd0, 32'(causeIp[7]));
        step(1);
        compareWord("causeIp7", 32'd1, 32'(causeIp[7]));
        compareWord("cause TI", 32'd1, 32'(rdData[30]));
        step(4);
        writeReg(addrCompare, 3'd0, '1);
        compareWord("cause TI clear", 32'd0, 32'(rdData[30]));

        testName = "exceptions";
        writeReg(addrStatus, 3'd0, 32'h0040_0000);   // BEV only, EXL clear
        repeat (6) begin
            pick  = 5'(randomBits(4) % 9 + 1);      // Interrupt through Trap
            pc    = randomBits(32) & ~32'd3;
            ds    = (randomBits(1) != 32'd0);
            value = ds ? pc - 32'd4 : pc;
            raiseException(excType_e'(pick), pc, ds, randomBits(32));
            compareWord("exl", 32'd1, 32'(statusExl));
            compareWord("epc", value, epc);
            readReg(addrCause, 3'd0);
            readReg(addrBadVAddr, 3'd0);
            raiseException(excAddrErrLoad, randomBits(32) & ~32'd3, 1'b1, randomBits(32));
            compareWord("epc held", value, epc);
            raiseException(excEret, randomBits(32), 1'b0, randomBits(32));
            compareWord("exl after eret", 32'd0, 32'(statusExl));
            raiseException(excRefetch, randomBits(32), 1'b1, randomBits(32));
            compareWord("exl after refetch", 32'd0, 32'(statusExl));
            compareWord("epc after refetch", value, epc);
        end

        testName = "interrupt inputs";
        rdAddr   = addrCause;
        repeat (8) begin
            irq       = 6'(randomBits(6));
            interrupt = irq;
            step(1);
            compareWord("causeIp hw", 32'(irq), 32'(causeIp[7:2]));
        end
        interrupt = '0;
        step(2);

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
